//--- src.f
verilog/pe_pkg.sv
verilog/pe_periph_if.sv
verilog/pe_bus_decoder.sv
verilog/pe_rtc.sv
verilog/pe_plic.sv
verilog/pe_periph_top.sv
testbench/pe_periph_properties.sv
testbench/tb_pe_periph.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_pe_periph
FILELIST  := src.f
BUILD     := obj_dir
PASS      := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- testbench/pe_periph_testdata.txt
# op  address(hex)  data(hex)  expected(hex), one operation per line
# W R RM GT DR DW NR IRQ ACK BIT IDLE WAITSET WAITCLR (bit number in data)
DR       01000124  00000000  00000000
DW       010000a8  cafef00d  00000005
NR       08000010  00000000  00000000
W        02000008  12345678  00000000
W        0200000c  9abcdef0  00000000
R        02000008  00000000  12345678
R        0200000c  00000000  9abcdef0
RM       02000000  00000000  00000000
IDLE     00000000  00000005  00000000
GT       02000000  00000000  00000000
W        0200000c  00000000  00000000
W        02000008  00000080  00000000
WAITSET  00000000  00000007  00000000
W        0200000c  ffffffff  00000000
W        02000008  ffffffff  00000000
WAITCLR  00000000  00000007  00000000
IRQ      00000000  00000001  00000000
R        04000004  00000000  00000001
BIT      00000000  0000000b  00000000
W        04000000  00000001  00000000
WAITSET  00000000  0000000b  00000000
R        04000008  00000000  00000001
IRQ      00000000  00000000  00000000
ACK      00000000  00000000  00000000
BIT      00000000  0000000b  00000000
R        04000008  00000000  00000000
R        02000008  00000000  ffffffff
R        04000000  00000000  00000001
IDLE     00000000  00000001  00000000

//--- testbench/tb_pe_periph.sv
`timescale 1ns/1ps

module tb_pe_periph;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              cpu_en_i;
    pe_pkg::strobe_t   cpu_we_i;
    pe_pkg::addr_t     cpu_addr_i;
    pe_pkg::word_t     cpu_wdata_i;
    pe_pkg::word_t     cpu_rdata_o;
    logic              dmem_en_o;
    pe_pkg::strobe_t   dmem_we_o;
    pe_pkg::offset_t   dmem_addr_o;
    pe_pkg::word_t     dmem_wdata_o;
    pe_pkg::word_t     dmem_rdata_i;
    logic              ext_irq_i;
    logic              irq_ack_i;
    pe_pkg::irq_vec_t  irq_o;
    pe_pkg::mtime_t    mtime_o;

    integer            seed = 47;
    string             test_name;
    logic              irq_level;
    logic              ack_pulse;
    // Read issued last cycle, checked in this one
    string             pend_kind;
    string             pend_name;
    pe_pkg::word_t     pend_exp;
    pe_pkg::word_t     last_rdata;
    // Timer ticks since reset release
    pe_pkg::mtime_t    mtime_exp;

    always #20 clk_i = ~clk_i;

    pe_periph_top pe_periph_top_inst (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .cpu_en_i     (cpu_en_i    ),
        .cpu_we_i     (cpu_we_i    ),
        .cpu_addr_i   (cpu_addr_i  ),
        .cpu_wdata_i  (cpu_wdata_i ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .dmem_we_o    (dmem_we_o   ),
        .dmem_addr_o  (dmem_addr_o ),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .ext_irq_i    (ext_irq_i   ),
        .irq_ack_i    (irq_ack_i   ),
        .irq_o        (irq_o       ),
        .mtime_o      (mtime_o     )
    );

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input pe_pkg::word_t expected,
                              input pe_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_mtime(input string name, input pe_pkg::mtime_t expected,
                               input pe_pkg::mtime_t actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s mtime_o: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_greater(input string name, input pe_pkg::word_t earlier,
                                 input pe_pkg::word_t actual);
        assert (actual > earlier) else begin
            $display("Mismatch in %s: expected more than %h, actual %h", name, earlier, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus driver
    ////////////////////////////////////////////////////////////

    // Drive at the rising edge, sample at the falling edge
    task automatic bus_cycle(input logic en, input pe_pkg::strobe_t we,
                             input pe_pkg::addr_t addr, input pe_pkg::word_t wdata,
                             input string kind, input pe_pkg::word_t expected);
        pe_pkg::word_t dmem_word;
        dmem_word = $random(seed);
        @(posedge clk_i);
        mtime_exp    = mtime_exp + 64'd1;
        cpu_en_i     <= en;
        cpu_we_i     <= we;
        cpu_addr_i   <= addr;
        cpu_wdata_i  <= wdata;
        dmem_rdata_i <= dmem_word;
        ext_irq_i    <= irq_level;
        irq_ack_i    <= ack_pulse;
        @(negedge clk_i);
        check_mtime(test_name, mtime_exp, mtime_o);
        if (pend_kind == "DM")
            check_word(pend_name, dmem_word, cpu_rdata_o);
        else if (pend_kind == "EQ")
            check_word(pend_name, pend_exp, cpu_rdata_o);
        else if (pend_kind == "GT")
            check_greater(pend_name, last_rdata, cpu_rdata_o);
        if (pend_kind != "")
            last_rdata = cpu_rdata_o;
        pend_kind = kind;
        pend_name = test_name;
        pend_exp  = expected;
        ack_pulse = 1'b0;
    endtask

    task automatic idle_cycle();
        bus_cycle(1'b0, '0, '0, '0, "", '0);
    endtask

    task automatic wait_irq_bit(input logic [4:0] idx, input logic level);
        int cycles;
        cycles = 0;
        while (irq_o[idx] !== level) begin
            if (cycles == 1000) begin
                $display("Timeout: irq_o bit %0d did not go to %0b in 1000 cycles", idx, level);
                abort_run();
            end
            idle_cycle();
            cycles++;
        end
    endtask

    initial begin
        int             fd;
        int             code;
        int             line_no;
        string          line;
        string          op;
        pe_pkg::addr_t  addr;
        pe_pkg::word_t  data;
        pe_pkg::word_t  expected;

        rst_ni       = 1'b0;
        cpu_en_i     = 1'b0;
        cpu_we_i     = '0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        dmem_rdata_i = '0;
        ext_irq_i    = 1'b0;
        irq_ack_i    = 1'b0;
        irq_level    = 1'b0;
        ack_pulse    = 1'b0;
        pend_kind    = "";
        last_rdata   = '0;
        mtime_exp    = '0;
        line_no      = 0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        fd = $fopen("testbench/pe_periph_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            if (code == 0 || line.len() < 4 || line[0] == "#")
                continue;
            if ($sscanf(line, "%s %h %h %h", op, addr, data, expected) != 4) begin
                $display("Malformed test data on line %0d", line_no);
                abort_run();
            end
            test_name = $sformatf("%s at line %0d", op, line_no);
            case (op)
                "W":    bus_cycle(1'b1, 4'hF, addr, data, "", '0);
                "R":    bus_cycle(1'b1, '0, addr, '0, "EQ", expected);
                "RM":   bus_cycle(1'b1, '0, addr, '0, "RM", '0);
                "GT":   bus_cycle(1'b1, '0, addr, '0, "GT", '0);
                "DR": begin
                    bus_cycle(1'b1, '0, addr, '0, "DM", '0);
                    check_word(test_name, 32'(1'b1), 32'(dmem_en_o));
                    check_word(test_name, 32'(addr[23:0]), 32'(dmem_addr_o));
                    check_word(test_name, '0, 32'(dmem_we_o));
                end
                "DW": begin
                    bus_cycle(1'b1, expected[3:0], addr, data, "", '0);
                    check_word(test_name, 32'(expected[3:0]), 32'(dmem_we_o));
                    check_word(test_name, data, dmem_wdata_o);
                end
                // Unmapped region falls back to memory data without a strobe
                "NR": begin
                    bus_cycle(1'b1, '0, addr, '0, "DM", '0);
                    check_word(test_name, '0, 32'(dmem_en_o));
                end
                "IRQ": begin
                    irq_level = data[0];
                    idle_cycle();
                end
                "ACK": begin
                    ack_pulse = 1'b1;
                    idle_cycle();
                end
                "BIT": begin
                    idle_cycle();
                    check_word(test_name, 32'(expected[0]), 32'(irq_o[data[4:0]]));
                end
                "IDLE":    repeat (data) idle_cycle();
                "WAITSET": wait_irq_bit(data[4:0], 1'b1);
                "WAITCLR": wait_irq_bit(data[4:0], 1'b0);
                default: begin
                    $display("Unknown operation %s on line %0d", op, line_no);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- testbench/pe_periph_properties.sv
`timescale 1ns/1ps

module pe_periph_properties (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              cpu_en_i,
    input  pe_pkg::addr_t     cpu_addr_i,
    input  logic              dmem_en_o,
    input  pe_pkg::irq_vec_t  irq_o
);

    dmem_en_in_region: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmem_en_o |-> (cpu_en_i && (cpu_addr_i[31:24] == pe_pkg::REGION_DMEM)))
        else $error("dmem_en_o high outside the data memory region");

    // Only the timer and external lines may ever be set
    irq_unused_bits_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irq_o & ~((pe_pkg::irq_vec_t'(1) << pe_pkg::IRQ_MTI_BIT)
                 | (pe_pkg::irq_vec_t'(1) << pe_pkg::IRQ_MEI_BIT))) == '0)
        else $error("irq_o has a bit set other than the timer or external line");

    irq_zero_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (irq_o == '0))
        else $error("irq_o not zero in the first cycle after reset release");

endmodule

bind pe_periph_top pe_periph_properties pe_periph_properties_inst (
    .clk_i      (clk_i     ),
    .rst_ni     (rst_ni    ),
    .cpu_en_i   (cpu_en_i  ),
    .cpu_addr_i (cpu_addr_i),
    .dmem_en_o  (dmem_en_o ),
    .irq_o      (irq_o     )
);

//--- verilog/pe_periph_top.sv
`timescale 1ns/1ps

module pe_periph_top (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Core data bus
    input  logic                cpu_en_i,
    input  pe_pkg::strobe_t     cpu_we_i,
    input  pe_pkg::addr_t       cpu_addr_i,
    input  pe_pkg::word_t       cpu_wdata_i,
    output pe_pkg::word_t       cpu_rdata_o,

    // External data memory
    output logic                dmem_en_o,
    output pe_pkg::strobe_t     dmem_we_o,
    output pe_pkg::offset_t     dmem_addr_o,
    output pe_pkg::word_t       dmem_wdata_o,
    input  pe_pkg::word_t       dmem_rdata_i,

    // Interrupts and timer
    input  logic                ext_irq_i,
    input  logic                irq_ack_i,
    output pe_pkg::irq_vec_t    irq_o,
    output pe_pkg::mtime_t      mtime_o
);

    logic  mti;
    logic  mei;

    pe_periph_if rtc_bus ();
    pe_periph_if plic_bus ();

    ////////////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////////////

    pe_bus_decoder pe_bus_decoder_inst (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .cpu_en_i     (cpu_en_i    ),
        .cpu_we_i     (cpu_we_i    ),
        .cpu_addr_i   (cpu_addr_i  ),
        .cpu_wdata_i  (cpu_wdata_i ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .dmem_we_o    (dmem_we_o   ),
        .dmem_addr_o  (dmem_addr_o ),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .rtc_bus      (rtc_bus     ),
        .plic_bus     (plic_bus    )
    );

    ////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////

    pe_rtc pe_rtc_inst (
        .clk_i   (clk_i  ),
        .rst_ni  (rst_ni ),
        .bus     (rtc_bus),
        .mti_o   (mti    ),
        .mtime_o (mtime_o)
    );

    pe_plic pe_plic_inst (
        .clk_i  (clk_i    ),
        .rst_ni (rst_ni   ),
        .bus    (plic_bus ),
        .irq_i  (ext_irq_i),
        .iack_i (irq_ack_i),
        .mei_o  (mei      )
    );

    // Machine timer and machine external lines of the core vector
    always_comb begin
        irq_o = '0;
        irq_o[pe_pkg::IRQ_MTI_BIT] = mti;
        irq_o[pe_pkg::IRQ_MEI_BIT] = mei;
    end

endmodule

//--- verilog/pe_plic.sv
`timescale 1ns/1ps

module pe_plic (
    input  logic   clk_i,
    input  logic   rst_ni,

    pe_periph_if.slave  bus,

    input  logic   irq_i,
    input  logic   iack_i,
    output logic   mei_o
);

    logic  enable_q;
    logic  pending_q;
    logic  wr_en;
    logic  rd_en;

    assign wr_en = bus.sel && (|bus.we);
    assign rd_en = bus.sel && !(|bus.we);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            enable_q <= 1'b0;
        else if (wr_en && (bus.offset == pe_pkg::PLIC_ENABLE))
            enable_q <= bus.wdata[0];
    end

    // Acknowledge wins over a request in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            pending_q <= 1'b0;
        else if (iack_i)
            pending_q <= 1'b0;
        else if (irq_i)
            pending_q <= 1'b1;
    end

    // Claim only reports the source, pending stays until the ack
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            case (bus.offset)
                pe_pkg::PLIC_ENABLE:  bus.rdata <= {31'b0, enable_q};
                pe_pkg::PLIC_PENDING: bus.rdata <= {31'b0, pending_q};
                pe_pkg::PLIC_CLAIM:
                    bus.rdata <= pending_q ? pe_pkg::PLIC_SOURCE_ID : '0;
                default:              bus.rdata <= '0;
            endcase
        end
    end

    assign mei_o = pending_q && enable_q;

endmodule

//--- verilog/pe_rtc.sv
`timescale 1ns/1ps

module pe_rtc (
    input  logic              clk_i,
    input  logic              rst_ni,

    pe_periph_if.slave        bus,

    output logic              mti_o,
    output pe_pkg::mtime_t    mtime_o
);

    pe_pkg::mtime_t  mtime_q;
    pe_pkg::mtime_t  mtimecmp_q;
    logic            wr_en;
    logic            rd_en;

    assign wr_en = bus.sel && (|bus.we);
    assign rd_en = bus.sel && !(|bus.we);

    ////////////////////////////////////////////////////////////
    // Timer and compare registers
    ////////////////////////////////////////////////////////////

    // A write to either mtime half takes the place of the tick
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else if (wr_en && (bus.offset == pe_pkg::RTC_MTIME_LO)) begin
            mtime_q <= {mtime_q[63:32], bus.wdata};
        end else if (wr_en && (bus.offset == pe_pkg::RTC_MTIME_HI)) begin
            mtime_q <= {bus.wdata, mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= pe_pkg::RTC_CMP_RESET;
        end else if (wr_en) begin
            if (bus.offset == pe_pkg::RTC_CMP_LO)
                mtimecmp_q[31:0] <= bus.wdata;
            else if (bus.offset == pe_pkg::RTC_CMP_HI)
                mtimecmp_q[63:32] <= bus.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port, valid the cycle after the access
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            case (bus.offset)
                pe_pkg::RTC_MTIME_LO: bus.rdata <= mtime_q[31:0];
                pe_pkg::RTC_MTIME_HI: bus.rdata <= mtime_q[63:32];
                pe_pkg::RTC_CMP_LO:   bus.rdata <= mtimecmp_q[31:0];
                pe_pkg::RTC_CMP_HI:   bus.rdata <= mtimecmp_q[63:32];
                default:              bus.rdata <= '0;
            endcase
        end
    end

    // Level interrupt, held while the compare value is reached
    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

endmodule

//--- verilog/pe_bus_decoder.sv
`timescale 1ns/1ps

module pe_bus_decoder (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Core data bus
    input  logic              cpu_en_i,
    input  pe_pkg::strobe_t   cpu_we_i,
    input  pe_pkg::addr_t     cpu_addr_i,
    input  pe_pkg::word_t     cpu_wdata_i,
    output pe_pkg::word_t     cpu_rdata_o,

    // External data memory
    output logic              dmem_en_o,
    output pe_pkg::strobe_t   dmem_we_o,
    output pe_pkg::offset_t   dmem_addr_o,
    output pe_pkg::word_t     dmem_wdata_o,
    input  pe_pkg::word_t     dmem_rdata_i,

    // Memory-mapped peripherals
    pe_periph_if.master       rtc_bus,
    pe_periph_if.master       plic_bus
);

    pe_pkg::region_t  region;
    pe_pkg::offset_t  offset;
    pe_pkg::rd_sel_e  rd_sel_d;
    pe_pkg::rd_sel_e  rd_sel_q;

    assign region = cpu_addr_i[31:24];
    assign offset = cpu_addr_i[23:0];

    // One strobe per region, unmapped regions raise none
    assign dmem_en_o    = cpu_en_i && (region == pe_pkg::REGION_DMEM);
    assign rtc_bus.sel  = cpu_en_i && (region == pe_pkg::REGION_RTC);
    assign plic_bus.sel = cpu_en_i && (region == pe_pkg::REGION_PLIC);

    assign dmem_we_o    = cpu_we_i;
    assign dmem_addr_o  = offset;
    assign dmem_wdata_o = cpu_wdata_i;

    assign rtc_bus.we      = cpu_we_i;
    assign rtc_bus.offset  = offset;
    assign rtc_bus.wdata   = cpu_wdata_i;
    assign plic_bus.we     = cpu_we_i;
    assign plic_bus.offset = offset;
    assign plic_bus.wdata  = cpu_wdata_i;

    always_comb begin
        if (rtc_bus.sel)
            rd_sel_d = pe_pkg::RD_RTC;
        else if (plic_bus.sel)
            rd_sel_d = pe_pkg::RD_PLIC;
        else
            rd_sel_d = pe_pkg::RD_DMEM;
    end

    // Read data arrives one cycle later, so remember where it comes from
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            rd_sel_q <= pe_pkg::RD_DMEM;
        else
            rd_sel_q <= rd_sel_d;
    end

    always_comb begin
        case (rd_sel_q)
            pe_pkg::RD_RTC:  cpu_rdata_o = rtc_bus.rdata;
            pe_pkg::RD_PLIC: cpu_rdata_o = plic_bus.rdata;
            default:         cpu_rdata_o = dmem_rdata_i;
        endcase
    end

endmodule

//--- verilog/pe_periph_if.sv
`timescale 1ns/1ps

interface pe_periph_if;

    // Single-cycle strobe bus, a write when any we bit is set
    logic              sel;
    pe_pkg::strobe_t   we;
    pe_pkg::offset_t   offset;
    pe_pkg::word_t     wdata;
    pe_pkg::word_t     rdata;

    modport master (
        output sel,
        output we,
        output offset,
        output wdata,
        input  rdata
    );

    modport slave (
        input  sel,
        input  we,
        input  offset,
        input  wdata,
        output rdata
    );

endinterface

//--- verilog/pe_pkg.sv
package pe_pkg;

    ////////////////////////////////////////////////////////////
    // Bus and timer types
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  region_t;
    typedef logic [23:0] offset_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [63:0] mtime_t;
    typedef logic [31:0] irq_vec_t;

    // Source of the read data returned in the cycle after an access
    typedef enum logic [1:0] {
        RD_DMEM,
        RD_RTC,
        RD_PLIC
    } rd_sel_e;

    ////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////

    // Region codes, top address byte
    localparam region_t REGION_DMEM = 8'h01;
    localparam region_t REGION_RTC  = 8'h02;
    localparam region_t REGION_PLIC = 8'h04;

    // RTC registers
    localparam offset_t RTC_MTIME_LO = 24'h00_0000;
    localparam offset_t RTC_MTIME_HI = 24'h00_0004;
    localparam offset_t RTC_CMP_LO   = 24'h00_0008;
    localparam offset_t RTC_CMP_HI   = 24'h00_000C;
    localparam mtime_t  RTC_CMP_RESET = {64{1'b1}};

    // PLIC registers
    localparam offset_t PLIC_ENABLE    = 24'h00_0000;
    localparam offset_t PLIC_PENDING   = 24'h00_0004;
    localparam offset_t PLIC_CLAIM     = 24'h00_0008;
    localparam word_t   PLIC_SOURCE_ID = 32'd1;

    // Positions in the core interrupt vector
    localparam int unsigned IRQ_MTI_BIT = 7;
    localparam int unsigned IRQ_MEI_BIT = 11;

endpackage
